/* Makefile */
# Verilator simulation of the event path

VERILATOR ?= verilator
TOP       ?= tb_digital_core
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Finished with no errors" $(LOG) || (echo "simulation incomplete"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* flist.f */
+incdir+hdl
hdl/digital_core_pkg.sv
hdl/event_fifo_if.sv
hdl/channel_ctrl.sv
hdl/channel_bank.sv
hdl/event_router.sv
hdl/event_fifo.sv
hdl/uart_tx.sv
hdl/digital_core.sv
tests/tb_clk_gen.sv
tests/digital_core_assert.sv
tests/tb_digital_core.sv

/* hdl/channel_bank.sv */
// Channel bank with shared timestamp
`timescale 1ns/1ps
`default_nettype none

`include "digital_core_params.svh"

module channel_bank (
    input wire logic clk,
    input wire logic rst_i,
    input wire logic [`NUM_CHANNELS-1:0] hit_i,
    input wire logic [`NUM_CHANNELS-1:0] done_i,
    input wire digital_core_pkg::adc_word_t [`NUM_CHANNELS-1:0] dout_i,
    input wire logic [`NUM_CHANNELS-1:0] channel_mask_i,
    input wire logic [`NUM_CHANNELS-1:0] ack_i,
    output logic [`NUM_CHANNELS-1:0] sample_o,
    output logic [`NUM_CHANNELS-1:0] strobe_o,
    output logic [`NUM_CHANNELS-1:0] ready_o,
    output digital_core_pkg::adc_word_t [`NUM_CHANNELS-1:0] adc_o,
    output digital_core_pkg::timestamp_t [`NUM_CHANNELS-1:0] ts_o
);

    digital_core_pkg::timestamp_t timestamp;    // one counter for every channel

    // free running, wraps at full scale
    always_ff @(posedge clk) begin
        if (rst_i) timestamp <= '0;
        else timestamp <= timestamp + 1'b1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // one controller per pixel
    for (genvar g = 0; g < `NUM_CHANNELS; g++) begin : g_chan
        channel_ctrl u_channel_ctrl (
            .clk         (clk),
            .rst_i       (rst_i),
            .hit_i       (hit_i[g]),
            .done_i      (done_i[g]),
            .dout_i      (dout_i[g]),
            .mask_i      (channel_mask_i[g]),
            .timestamp_i (timestamp),
            .ack_i       (ack_i[g]),
            .sample_o    (sample_o[g]),
            .strobe_o    (strobe_o[g]),
            .ready_o     (ready_o[g]),
            .adc_o       (adc_o[g]),
            .ts_o        (ts_o[g])
        );
    end

endmodule

`default_nettype wire

/* hdl/channel_ctrl.sv */
// Pixel channel controller
`timescale 1ns/1ps
`default_nettype none

`include "digital_core_params.svh"

module channel_ctrl (
    input wire logic clk,
    input wire logic rst_i,
    input wire logic hit_i,                             // discriminator fired
    input wire logic done_i,                            // adc conversion finished
    input wire digital_core_pkg::adc_word_t dout_i,     // adc result
    input wire logic mask_i,                            // high disables channel
    input wire digital_core_pkg::timestamp_t timestamp_i,
    input wire logic ack_i,                             // router took the event
    output logic sample_o,                              // hold csa output
    output logic strobe_o,                              // start adc
    output logic ready_o,                               // event waiting
    output digital_core_pkg::adc_word_t adc_o,
    output digital_core_pkg::timestamp_t ts_o
);

    localparam int HOLD_W = $clog2(`HOLD_CYCLES + 1);

    digital_core_pkg::chan_state_t state_q;
    logic [HOLD_W-1:0] hold_cnt;        // cycles spent in hold
    logic strobe_q;
    logic hold_last;

    assign hold_last = (hold_cnt == HOLD_W'(`HOLD_CYCLES - 1));

    ////////////////////////////////////////////////////////////////////////////
    // hit -> hold -> convert -> ready
    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= digital_core_pkg::IDLE;
            hold_cnt <= '0;
            strobe_q <= 1'b0;
        end else begin
            strobe_q <= 1'b0;                           // strobe is one cycle
            case (state_q)
                digital_core_pkg::IDLE: begin
                    if (hit_i && !mask_i) begin
                        state_q <= digital_core_pkg::HOLD;
                        hold_cnt <= '0;
                    end
                end
                digital_core_pkg::HOLD: begin
                    if (hold_last) begin
                        state_q <= digital_core_pkg::CONVERT;
                        strobe_q <= 1'b1;               // first cycle after sample
                    end else begin
                        hold_cnt <= hold_cnt + 1'b1;
                    end
                end
                digital_core_pkg::CONVERT: begin
                    if (done_i) state_q <= digital_core_pkg::READY;
                end
                digital_core_pkg::READY: begin
                    if (ack_i) state_q <= digital_core_pkg::IDLE;  // rearm after ack
                end
                default: state_q <= digital_core_pkg::IDLE;
            endcase
        end
    end

    // event payload, timestamp at hit and adc at done
    always_ff @(posedge clk) begin
        if (state_q == digital_core_pkg::IDLE && hit_i && !mask_i) ts_o <= timestamp_i;
        if (state_q == digital_core_pkg::CONVERT && done_i) adc_o <= dout_i;
    end

    assign sample_o = (state_q == digital_core_pkg::HOLD);
    assign strobe_o = strobe_q;
    assign ready_o = (state_q == digital_core_pkg::READY);     // level until ack

endmodule

`default_nettype wire

/* hdl/digital_core.sv */
// Pixel chip event path
`timescale 1ns/1ps
`default_nettype none

`include "digital_core_params.svh"

module digital_core (
    input wire logic clk,                                   // core clock
    input wire logic rst_i,
    input wire logic [`NUM_CHANNELS-1:0] hit_i,             // discriminator hits
    input wire logic [`NUM_CHANNELS-1:0] done_i,            // adc finished
    input wire digital_core_pkg::adc_word_t [`NUM_CHANNELS-1:0] dout_i,
    input wire digital_core_pkg::chip_id_t chip_id_i,
    input wire logic [`NUM_CHANNELS-1:0] channel_mask_i,    // high to disable
    output logic [`NUM_CHANNELS-1:0] sample_o,              // hold csa output
    output logic [`NUM_CHANNELS-1:0] strobe_o,              // start adc
    output logic piso_o                                     // serial events
);

    logic [`NUM_CHANNELS-1:0] chan_ready;
    logic [`NUM_CHANNELS-1:0] chan_ack;
    digital_core_pkg::adc_word_t [`NUM_CHANNELS-1:0] chan_adc;
    digital_core_pkg::timestamp_t [`NUM_CHANNELS-1:0] chan_ts;

    event_fifo_if fifo_bus ();      // router -> fifo -> tx

    ////////////////////////////////////////////////////////////////////////////
    // producer, buffer, consumer
    channel_bank u_channel_bank (
        .clk(clk), .rst_i(rst_i),
        .hit_i(hit_i), .done_i(done_i), .dout_i(dout_i),
        .channel_mask_i(channel_mask_i), .ack_i(chan_ack),
        .sample_o(sample_o), .strobe_o(strobe_o),
        .ready_o(chan_ready), .adc_o(chan_adc), .ts_o(chan_ts)
    );

    event_router u_event_router (
        .clk(clk), .rst_i(rst_i),
        .ready_i(chan_ready), .adc_i(chan_adc), .ts_i(chan_ts),
        .chip_id_i(chip_id_i), .ack_o(chan_ack),
        .fifo_bus(fifo_bus.writer)
    );

    event_fifo #(.DEPTH(`FIFO_DEPTH)) u_event_fifo (
        .clk(clk), .rst_i(rst_i), .fifo_bus(fifo_bus.fifo)
    );

    uart_tx u_uart_tx (
        .clk(clk), .rst_i(rst_i), .fifo_bus(fifo_bus.reader), .piso_o(piso_o)
    );

endmodule

`default_nettype wire

/* hdl/digital_core_params.svh */
// Event path sizing constants
`ifndef DIGITAL_CORE_PARAMS_SVH
`define DIGITAL_CORE_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// channel side
`define NUM_CHANNELS 4      // pixel channels in the bank
`define ADC_BITS 10         // SAR word
`define TS_BITS 24          // free running timestamp
`define HOLD_CYCLES 4       // sample high before strobe

////////////////////////////////////////////////////////////////////////////
// event word and transport
`define CHAN_ID_BITS 6      // channel field in event
`define CHIP_ID_BITS 8      // chip field in event
`define EVENT_BITS 48       // adc + ts + chan + chip
`define FIFO_DEPTH 8        // shared event fifo entries

`endif

/* hdl/digital_core_pkg.sv */
// Event path types
`default_nettype none

`include "digital_core_params.svh"

package digital_core_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // field vectors
    typedef logic [`ADC_BITS-1:0] adc_word_t;           // one conversion
    typedef logic [`TS_BITS-1:0] timestamp_t;           // hit time
    typedef logic [`CHAN_ID_BITS-1:0] chan_id_t;        // channel index
    typedef logic [`CHIP_ID_BITS-1:0] chip_id_t;        // chip address

    // event layout, lsb first: adc 9:0, ts 33:10, chan 39:34, chip 47:40
    typedef logic [`EVENT_BITS-1:0] event_word_t;

    ////////////////////////////////////////////////////////////////////////////
    // state machines
    typedef enum logic [1:0] {
        IDLE,       // armed, waiting for hit
        HOLD,       // sample high, csa held
        CONVERT,    // strobe sent, waiting on done
        READY       // event waiting for router
    } chan_state_t;

    typedef enum logic [2:0] {
        TX_IDLE,    // line high, watching fifo
        TX_START,   // start bit
        TX_DATA,    // payload, lsb first
        TX_PARITY,  // odd parity
        TX_STOP     // stop bit
    } tx_state_t;

endpackage

`default_nettype wire

/* hdl/event_fifo.sv */
// Shared event FIFO
`timescale 1ns/1ps
`default_nettype none

`include "digital_core_params.svh"

module event_fifo #(
    parameter int DEPTH = `FIFO_DEPTH       // entries
) (
    input wire logic clk,
    input wire logic rst_i,
    event_fifo_if.fifo fifo_bus
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    digital_core_pkg::event_word_t mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;       // occupancy
    logic push;
    logic pop;

    assign push = fifo_bus.wr_en && !fifo_bus.full;
    assign pop = fifo_bus.rd_en && !fifo_bus.empty;

    ////////////////////////////////////////////////////////////////////////////
    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop) rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;        // both or neither
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= fifo_bus.wr_data;
    end

    assign fifo_bus.rd_data = mem[rd_ptr];      // show-ahead
    assign fifo_bus.full = (count == CW'(DEPTH));
    assign fifo_bus.empty = (count == '0);

endmodule

`default_nettype wire

/* hdl/event_fifo_if.sv */
// Event FIFO bus
`timescale 1ns/1ps
`default_nettype none

interface event_fifo_if;

    logic wr_en;                                // push strobe
    digital_core_pkg::event_word_t wr_data;     // word to push
    logic full;                                 // no room left
    logic empty;                                // nothing stored
    digital_core_pkg::event_word_t rd_data;     // oldest entry, show-ahead
    logic rd_en;                                // pop strobe

    // router side
    modport writer (
        output wr_en, wr_data,
        input full
    );

    // storage
    modport fifo (
        input wr_en, wr_data, rd_en,
        output full, empty, rd_data
    );

    // serial tx side
    modport reader (
        output rd_en,
        input rd_data, empty
    );

endinterface

`default_nettype wire

/* hdl/event_router.sv */
// Round robin event router
`timescale 1ns/1ps
`default_nettype none

`include "digital_core_params.svh"

module event_router (
    input wire logic clk,
    input wire logic rst_i,
    input wire logic [`NUM_CHANNELS-1:0] ready_i,
    input wire digital_core_pkg::adc_word_t [`NUM_CHANNELS-1:0] adc_i,
    input wire digital_core_pkg::timestamp_t [`NUM_CHANNELS-1:0] ts_i,
    input wire digital_core_pkg::chip_id_t chip_id_i,
    output logic [`NUM_CHANNELS-1:0] ack_o,
    event_fifo_if.writer fifo_bus
);

    localparam int IDX_W = $clog2(`NUM_CHANNELS);

    logic [IDX_W-1:0] last_q;       // last granted channel
    logic [IDX_W-1:0] sel;          // channel picked this cycle
    logic found;
    logic grant;
    digital_core_pkg::chan_id_t chan_id;

    ////////////////////////////////////////////////////////////////////////////
    // search upward from last grant, wrapping
    always_comb begin
        int cand;
        found = 1'b0;
        sel = '0;
        for (int k = 1; k <= `NUM_CHANNELS; k++) begin
            cand = (int'(last_q) + k) % `NUM_CHANNELS;
            if (!found && ready_i[cand]) begin
                found = 1'b1;
                sel = IDX_W'(cand);
            end
        end
    end

    assign grant = found && !fifo_bus.full;     // hold everyone off while full
    assign chan_id = digital_core_pkg::chan_id_t'(sel);

    always_comb begin
        ack_o = '0;
        if (grant) ack_o[sel] = 1'b1;           // one hot, same cycle as write
    end

    // chip | chan | ts | adc
    assign fifo_bus.wr_en = grant;
    assign fifo_bus.wr_data = {chip_id_i, chan_id, ts_i[sel], adc_i[sel]};

    always_ff @(posedge clk) begin
        if (rst_i) last_q <= IDX_W'(`NUM_CHANNELS - 1);   // first search hits ch 0
        else if (grant) last_q <= sel;
    end

endmodule

`default_nettype wire

/* hdl/uart_tx.sv */
// Event serializer
`timescale 1ns/1ps
`default_nettype none

`include "digital_core_params.svh"

module uart_tx (
    input wire logic clk,
    input wire logic rst_i,
    event_fifo_if.reader fifo_bus,
    output logic piso_o             // serial event out, idles high
);

    localparam int BW = $clog2(`EVENT_BITS);

    digital_core_pkg::tx_state_t state_q;
    digital_core_pkg::event_word_t shift_q;     // payload, shifts right
    logic [BW-1:0] bit_cnt;                     // data bit position
    logic par_q;                                // running odd parity
    logic pop;

    // pop as soon as idle and something is stored
    assign pop = (state_q == digital_core_pkg::TX_IDLE) && !fifo_bus.empty;
    assign fifo_bus.rd_en = pop;

    ////////////////////////////////////////////////////////////////////////////
    // frame sequencing, 1 + 48 + 1 + 1 bits
    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= digital_core_pkg::TX_IDLE;
            bit_cnt <= '0;
        end else begin
            case (state_q)
                digital_core_pkg::TX_IDLE: begin
                    if (pop) state_q <= digital_core_pkg::TX_START;
                end
                digital_core_pkg::TX_START: begin
                    state_q <= digital_core_pkg::TX_DATA;
                    bit_cnt <= '0;
                end
                digital_core_pkg::TX_DATA: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == BW'(`EVENT_BITS - 1)) state_q <= digital_core_pkg::TX_PARITY;
                end
                digital_core_pkg::TX_PARITY: state_q <= digital_core_pkg::TX_STOP;
                digital_core_pkg::TX_STOP: state_q <= digital_core_pkg::TX_IDLE;
                default: state_q <= digital_core_pkg::TX_IDLE;
            endcase
        end
    end

    // load on pop, then shift one bit per data cycle
    always_ff @(posedge clk) begin
        if (pop) begin
            shift_q <= fifo_bus.rd_data;
            par_q <= 1'b1;                      // odd: seed with one
        end else if (state_q == digital_core_pkg::TX_DATA) begin
            shift_q <= shift_q >> 1;
            par_q <= par_q ^ shift_q[0];
        end
    end

    always_comb begin
        case (state_q)
            digital_core_pkg::TX_START: piso_o = 1'b0;
            digital_core_pkg::TX_DATA: piso_o = shift_q[0];   // lsb first
            digital_core_pkg::TX_PARITY: piso_o = par_q;
            default: piso_o = 1'b1;             // idle and stop
        endcase
    end

endmodule

`default_nettype wire

/* tests/digital_core_assert.sv */
// Event path port assertions
`timescale 1ns/1ps
`default_nettype none

`include "digital_core_params.svh"

module digital_core_assert (
    input wire logic clk,
    input wire logic rst_i,
    input wire logic [`NUM_CHANNELS-1:0] sample_i,
    input wire logic [`NUM_CHANNELS-1:0] strobe_i,
    input wire logic piso_i
);

    int unsigned fail_cnt = 0;                  // read by the testbench
    logic [7:0] hold_len [`NUM_CHANNELS];       // consecutive sample cycles
    logic [5:0] frame_pos;                      // 0 idle, 50 is the stop bit

    always_ff @(posedge clk) begin
        for (int k = 0; k < `NUM_CHANNELS; k++) begin
            hold_len[k] <= sample_i[k] ? hold_len[k] + 1'b1 : 8'd0;
        end
    end

    // follow the serial frame, start bit moves to position 1
    always_ff @(posedge clk) begin
        if (rst_i) frame_pos <= '0;
        else if (frame_pos == 6'd0) frame_pos <= piso_i ? 6'd0 : 6'd1;
        else if (frame_pos == 6'd50) frame_pos <= '0;
        else frame_pos <= frame_pos + 1'b1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // per channel sample and strobe shape
    for (genvar g = 0; g < `NUM_CHANNELS; g++) begin : g_chan
        a_hold_len: assert property (@(posedge clk) disable iff (rst_i)
            $fell(sample_i[g]) |-> hold_len[g] == 8'(`HOLD_CYCLES))
            else begin $error("sample width wrong on channel %0d", g); fail_cnt++; end
        a_strobe_follow: assert property (@(posedge clk) disable iff (rst_i)
            $fell(sample_i[g]) |-> strobe_i[g])
            else begin $error("no strobe after sample on channel %0d", g); fail_cnt++; end
        a_strobe_single: assert property (@(posedge clk) disable iff (rst_i)
            strobe_i[g] |=> !strobe_i[g])
            else begin $error("strobe longer than one cycle on channel %0d", g); fail_cnt++; end
    end

    ////////////////////////////////////////////////////////////////////////////
    // serial line
    a_idle_after_rst: assert property (@(posedge clk) $fell(rst_i) |-> piso_i)
        else begin $error("serial line low after reset"); fail_cnt++; end
    a_stop_bit: assert property (@(posedge clk) disable iff (rst_i)
        frame_pos == 6'd50 |-> piso_i)
        else begin $error("stop bit low"); fail_cnt++; end

endmodule

bind digital_core digital_core_assert u_core_assert (
    .clk      (clk),
    .rst_i    (rst_i),
    .sample_i (sample_o),
    .strobe_i (strobe_o),
    .piso_i   (piso_o)
);

`default_nettype wire

/* tests/tb_clk_gen.sv */
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;              // 4 ns period
    end

    // reset held for 8 rising edges, released on a falling edge
    initial begin
        rst_o = 1'b1;
        repeat (8) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

`default_nettype wire

/* tests/tb_digital_core.sv */
// Event path testbench
`timescale 1ns/1ps
`default_nettype none

`include "digital_core_params.svh"

module tb_digital_core;

    localparam int NCH = `NUM_CHANNELS;

    logic clk;
    logic rst_i;
    logic [NCH-1:0] hit_i;
    logic [NCH-1:0] done_i = '0;                        // driven by adc model
    logic [NCH-1:0][`ADC_BITS-1:0] dout_i = '0;
    logic [`CHIP_ID_BITS-1:0] chip_id_i;
    logic [NCH-1:0] channel_mask_i;
    logic [NCH-1:0] sample_o;
    logic [NCH-1:0] strobe_o;
    logic piso_o;

    integer seed = 49;
    int err_cnt = 0;
    int test_err0;                                      // errors at test start
    int tests_run = 0;
    int frames_rx = 0;                                  // frames matched
    int exp_pushed = 0;                                 // events produced
    int adc_fixed_dly = 0;                              // 0 picks random delay
    int samples_seen [NCH];
    logic [`TS_BITS-1:0] cyc;                           // own timestamp reference
    logic [NCH-1:0] hit_q;
    logic [`TS_BITS-1:0] hit_cyc_q;
    logic [NCH-1:0] sample_prev;
    logic [`TS_BITS-1:0] pending_ts [NCH];
    int adc_cnt [NCH];
    logic [`ADC_BITS-1:0] adc_val [NCH];
    logic [`EVENT_BITS-1:0] exp_q [$];                  // scoreboard
    int rx_chan [$];
    logic rx_busy = 1'b0;
    int rx_pos;
    logic [`EVENT_BITS-1:0] rx_word;
    logic rx_par;

    tb_clk_gen u_clk_gen (.clk_o(clk), .rst_o(rst_i));

    digital_core digital_core_i (
        .clk(clk), .rst_i(rst_i), .hit_i(hit_i), .done_i(done_i), .dout_i(dout_i),
        .chip_id_i(chip_id_i), .channel_mask_i(channel_mask_i),
        .sample_o(sample_o), .strobe_o(strobe_o), .piso_o(piso_o)
    );

    // zero in reset, +1 every cycle after
    always @(posedge clk) begin
        cyc <= rst_i ? '0 : cyc + 1'b1;
        hit_q <= hit_i;
        hit_cyc_q <= cyc;                               // value seen in the hit cycle
    end

    task automatic check_value(input string name, input longint got, input longint exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // monitor: sample tracking, adc model, serial receiver
    always @(negedge clk) begin
        int idx;
        if (!rst_i) begin
            for (int c = 0; c < NCH; c++) begin
                if (sample_o[c] && !sample_prev[c]) begin
                    samples_seen[c]++;
                    if (!hit_q[c]) begin
                        $display("sample pulse on channel %0d with no hit before it", c);
                        err_cnt++;
                    end
                    pending_ts[c] = hit_cyc_q;
                end
                done_i[c] = 1'b0;
                if (adc_cnt[c] > 0) begin
                    adc_cnt[c]--;
                    if (adc_cnt[c] == 0) begin
                        done_i[c] = 1'b1;
                        dout_i[c] = adc_val[c];
                        exp_q.push_back({chip_id_i, 6'(c), pending_ts[c], adc_val[c]});
                        exp_pushed++;
                    end
                end
                if (strobe_o[c]) begin              // start a conversion
                    adc_val[c] = `ADC_BITS'($random(seed));
                    adc_cnt[c] = (adc_fixed_dly != 0) ? adc_fixed_dly
                                 : 1 + int'($unsigned($random(seed)) % 6);
                end
            end
            sample_prev = sample_o;
            if (!rx_busy) begin
                if (piso_o == 1'b0) begin           // start bit
                    rx_busy = 1'b1;
                    rx_pos = 0;
                end
            end else begin
                if (rx_pos < `EVENT_BITS) rx_word[rx_pos] = piso_o;
                else if (rx_pos == `EVENT_BITS) rx_par = piso_o;
                else begin
                    rx_busy = 1'b0;
                    check_value("piso_o stop", piso_o, 1);
                    check_value("parity ones", ^{rx_word, rx_par}, 1);
                    idx = -1;
                    for (int i = 0; i < exp_q.size(); i++) begin
                        if (idx < 0 && exp_q[i] == rx_word) idx = i;
                    end
                    if (idx < 0) begin
                        $display("frame %h at %0t matches no expected event", rx_word, $time);
                        err_cnt++;
                    end else begin
                        exp_q.delete(idx);
                        frames_rx++;
                        rx_chan.push_back(int'(rx_word[39:34]));
                    end
                end
                rx_pos++;
            end
        end
    end

    task automatic pulse_hit(input logic [NCH-1:0] chans);
        @(negedge clk);
        hit_i = chans;
        @(negedge clk);
        hit_i = '0;
    endtask

    // quiet means nothing expected and receiver idle for 40 cycles
    task automatic wait_drain(input int limit);
        int quiet;
        int n;
        quiet = 0;
        n = 0;
        while (quiet < 40 && n < limit) begin
            @(posedge clk);
            n++;
            if (exp_q.size() == 0 && !rx_busy) quiet++;
            else quiet = 0;
        end
        if (quiet < 40) begin
            $display("timeout after %0d cycles waiting for events to drain", limit);
            err_cnt++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("test %-14s errors=%0d", name, err_cnt - test_err0);
        test_err0 = err_cnt;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    initial begin
        int f0;
        int s0;
        int n;
        int total;
        hit_i = '0;
        chip_id_i = 8'hA5;
        channel_mask_i = '0;
        for (int c = 0; c < NCH; c++) begin
            samples_seen[c] = 0;
            adc_cnt[c] = 0;
        end
        n = 0;
        while (rst_i !== 1'b0 && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (rst_i !== 1'b0) begin
            $display("reset never released");
            err_cnt++;
        end
        test_err0 = err_cnt;

        repeat (20) begin                               // 1 reset idle
            @(negedge clk);
            check_value("sample_o", sample_o, 0);
            check_value("strobe_o", strobe_o, 0);
            check_value("piso_o", piso_o, 1);
        end
        end_test("reset_idle");

        f0 = frames_rx;                                 // 2 single hit
        pulse_hit(4'b1000);
        wait_drain(600);
        check_value("frames", frames_rx - f0, 1);
        end_test("single_hit");

        @(negedge clk);
        channel_mask_i = 4'b0010;                       // 3 masked channel
        f0 = frames_rx;
        s0 = samples_seen[1];
        pulse_hit(4'b0010);
        repeat (150) @(posedge clk);
        check_value("sample_o[1] pulses", samples_seen[1] - s0, 0);
        check_value("frames", frames_rx - f0, 0);
        @(negedge clk);
        channel_mask_i = '0;
        end_test("mask");

        f0 = frames_rx;                                 // 4 busy channel
        pulse_hit(4'b1000);
        pulse_hit(4'b1000);                             // lands in hold
        repeat (2) @(negedge clk);
        pulse_hit(4'b1000);                             // lands in convert
        wait_drain(600);
        check_value("frames", frames_rx - f0, 1);
        end_test("busy");

        f0 = frames_rx;                                 // 5 all channels
        rx_chan.delete();
        adc_fixed_dly = 3;                              // all ready together
        pulse_hit('1);
        wait_drain(1000);
        adc_fixed_dly = 0;
        check_value("frames", frames_rx - f0, NCH);
        for (int i = 0; i < rx_chan.size(); i++) check_value("channel order", rx_chan[i], i);
        end_test("all_channels");

        f0 = frames_rx;                                 // 6 back-pressure
        s0 = exp_pushed;
        @(negedge clk);
        hit_i = '1;
        repeat (200) @(negedge clk);
        hit_i = '0;
        wait_drain(4000);
        if (exp_pushed - s0 <= `FIFO_DEPTH) begin
            $display("burst produced only %0d events, fifo never filled", exp_pushed - s0);
            err_cnt++;
        end
        check_value("frames", frames_rx - f0, exp_pushed - s0);
        end_test("back_pressure");

        total = err_cnt + int'(digital_core_i.u_core_assert.fail_cnt);
        $display("tests=%0d errors=%0d assertion_failures=%0d", tests_run, err_cnt,
                 digital_core_i.u_core_assert.fail_cnt);
        if (total == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
